/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing -Wno-fatal -j 0
TOP = gameCoreTb
FILELIST = gameCore.f
BUILD = obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out=$$(./$(BUILD)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf $(BUILD)

/* bench/clockGen.sv */
`timescale 1ns/1ps

module clockGen #(
	parameter int PERIOD = 4,
	parameter int RESET_CYCLES = 4
) (
	output logic clk,
	output logic resetN
);
	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		resetN = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		resetN = 1'b1;	// released on a falling edge
	end

endmodule

/* bench/gameCoreTb.sv */
`timescale 1ns/1ps

module gameCoreTb;
	import gamePkg::*;

	localparam int FRAC_BITS = 6;
	localparam int RUN_CYCLES = 20000;
	localparam int CYCLE_LIMIT = RUN_CYCLES * 12 / 10;

	logic clk;
	logic resetN;
	logic startOfFrame;
	logic leftKey;
	logic rightKey;
	logic pause;
	logic levelRestart;
	levelT level;
	pointT ballPos;
	coordT paddleX;
	collisionT collisions;
	logic ballLost;
	brickMaskT brickAlive;
	hitCountT hitCount;

	// model positions and speeds in fixed point
	int posX;
	int posY;
	int speedX;
	int speedY;
	int padX;	// whole pixels
	int padSpeed;
	brickMaskT alive;
	hitCountT hits;

	integer seed = 32'h2e8a_c5f0;
	int cycles = 0;
	int frameGap = 3;

	clockGen clocks (
		.clk	(clk),
		.resetN	(resetN)
	);

	gameCore #(
		.FRAC_BITS	(FRAC_BITS)
	) i_dut (
		.clk			(clk),
		.resetN			(resetN),
		.startOfFrame	(startOfFrame),
		.leftKey		(leftKey),
		.rightKey		(rightKey),
		.pause			(pause),
		.levelRestart	(levelRestart),
		.level			(level),
		.ballPos		(ballPos),
		.paddleX		(paddleX),
		.collisions		(collisions),
		.ballLost		(ballLost),
		.brickAlive		(brickAlive),
		.hitCount		(hitCount)
	);

	// ========================================================================
	// compare tasks
	// ========================================================================
	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "run stopped");
	endtask

	task automatic checkPoint(input string name, input pointT exp, input pointT act);
		if (exp !== act)
			abortRun($sformatf("[ERROR] %s at cycle %0d: expected (%0d,%0d), actual (%0d,%0d)",
				name, cycles, exp.x, exp.y, act.x, act.y));
	endtask

	task automatic checkCoord(input string name, input coordT exp, input coordT act);
		if (exp !== act)
			abortRun($sformatf("[ERROR] %s at cycle %0d: expected %0d, actual %0d",
				name, cycles, exp, act));
	endtask

	task automatic checkCollisions(input string name, input collisionT exp, input collisionT act);
		if (exp !== act)
			abortRun($sformatf("[ERROR] %s at cycle %0d: expected %b, actual %b",
				name, cycles, exp, act));
	endtask

	task automatic checkMask(input string name, input brickMaskT exp, input brickMaskT act);
		if (exp !== act)
			abortRun($sformatf("[ERROR] %s at cycle %0d: expected %b, actual %b",
				name, cycles, exp, act));
	endtask

	task automatic checkCount(input string name, input hitCountT exp, input hitCountT act);
		if (exp !== act)
			abortRun($sformatf("[ERROR] %s at cycle %0d: expected %0d, actual %0d",
				name, cycles, exp, act));
	endtask

	task automatic checkBit(input string name, input logic exp, input logic act);
		if (exp !== act)
			abortRun($sformatf("[ERROR] %s at cycle %0d: expected %b, actual %b",
				name, cycles, exp, act));
	endtask

	// ========================================================================
	// cycle model
	// ========================================================================
	function automatic pointT ballPoint();
		pointT p;
		p.x = coordT'(posX >>> FRAC_BITS);
		p.y = coordT'(posY >>> FRAC_BITS);
		return p;
	endfunction

	function automatic int overlap(input int a0, input int a1, input int b0, input int b1);
		return ((a1 < b1) ? a1 : b1) - ((a0 > b0) ? a0 : b0);
	endfunction

	// hitIdx stays -1 when no brick is touched
	function automatic collisionT expectCollisions(output int hitIdx);
		collisionT c;
		pointT p;
		int bx;
		int by;
		int left;
		int dx;
		int dy;
		p = ballPoint();
		bx = p.x;
		by = p.y;
		c = '0;
		hitIdx = -1;
		c.borderTop = by <= 0;
		c.borderLeft = bx <= 0;
		c.borderRight = bx + BALL_SIZE >= SCREEN_W;
		c.paddle = bx < padX + PADDLE_W && bx + BALL_SIZE > padX
			&& by < PADDLE_Y + PADDLE_H && by + BALL_SIZE > PADDLE_Y;
		for (int i = NUM_BRICKS - 1; i >= 0; i--) begin	// lowest index ends up winning
			left = BRICK_X0 + i * (BRICK_W + BRICK_GAP);
			if (((alive >> i) & 1) != 0 && bx < left + BRICK_W && bx + BALL_SIZE > left
					&& by < BRICK_Y + BRICK_H && by + BALL_SIZE > BRICK_Y)
				hitIdx = i;
		end
		if (hitIdx >= 0) begin
			left = BRICK_X0 + hitIdx * (BRICK_W + BRICK_GAP);
			c.brick = 1'b1;
			dx = overlap(bx, bx + BALL_SIZE, left, left + BRICK_W);
			dy = overlap(by, by + BALL_SIZE, BRICK_Y, BRICK_Y + BRICK_H);
			if (dx <= dy)
				c.brickEdge = (bx + BALL_SIZE / 2 > left + BRICK_W / 2) ? 4'b1000 : 4'b0010;
			else
				c.brickEdge = (by + BALL_SIZE / 2 > BRICK_Y + BRICK_H / 2) ? 4'b0100 : 4'b0001;
		end
		return c;
	endfunction

	task automatic placeModel(input int ySpeed);
		posX = INITIAL_X <<< FRAC_BITS;
		posY = INITIAL_Y <<< FRAC_BITS;
		speedX = 0;
		speedY = ySpeed <<< FRAC_BITS;
		padX = PADDLE_START_X;
		padSpeed = 0;
		alive = '1;
	endtask

	task automatic stepModel();
		collisionT c;
		int idx;
		int nextSpeedX;
		int nextSpeedY;
		int target;
		c = expectCollisions(idx);
		if (levelRestart) begin
			placeModel(INITIAL_Y_SPEED * (int'(level) + 1));
		end else if (!pause) begin
			nextSpeedY = speedY;
			if ((c.borderTop || c.brickEdge[2]) && speedY < 0
					|| (c.paddle || c.brickEdge[0]) && speedY > 0)
				nextSpeedY = -speedY;
			nextSpeedX = speedX;
			if ((c.borderLeft || c.brickEdge[3]) && speedX < 0
					|| (c.borderRight || c.brickEdge[1]) && speedX > 0)
				nextSpeedX = -speedX;
			else if (c.paddle && speedY > 0)
				nextSpeedX = speedX + padSpeed;	// paddle kick
			if (startOfFrame) begin
				posX += speedX;
				posY += speedY;
				target = padX + (int'(rightKey) - int'(leftKey)) * PADDLE_STEP;
				if (target < 0 || target > SCREEN_W - PADDLE_W) begin
					target = (target < 0) ? 0 : SCREEN_W - PADDLE_W;
					padSpeed = 0;
				end else
					padSpeed = (target - padX) <<< FRAC_BITS;
				padX = target;
			end
			speedX = nextSpeedX;
			speedY = nextSpeedY;
			if (idx >= 0) begin
				alive = alive & ~(brickMaskT'(1) << idx);
				hits++;
			end
		end
	endtask

	task automatic checkOutputs();
		collisionT c;
		pointT p;
		int idx;
		c = expectCollisions(idx);
		p = ballPoint();
		checkPoint("ballPos", p, ballPos);
		checkCoord("paddleX", coordT'(padX), paddleX);
		checkCollisions("collisions", c, collisions);
		checkBit("ballLost", p.y >= SCREEN_H, ballLost);
		checkMask("brickAlive", alive, brickAlive);
		checkCount("hitCount", hits, hitCount);
	endtask

	// ========================================================================
	// stimulus
	// ========================================================================
	task automatic driveInputs();
		pointT p;
		p = ballPoint();
		startOfFrame = frameGap == 0;
		frameGap = (frameGap == 0) ? 2 + int'({$random(seed)} % 4) : frameGap - 1;
		pause = ({$random(seed)} % 10) == 0;
		// restart a while after the ball is lost, and now and then anyway
		levelRestart = p.y >= SCREEN_H + 40 || ({$random(seed)} % 1500) == 0;
		if (levelRestart)
			level = levelT'({$random(seed)} % 16);
		if (({$random(seed)} % 4) == 0) begin
			leftKey = ($random(seed) & 1) != 0;
			rightKey = ($random(seed) & 1) != 0;
		end else begin
			leftKey = p.x + BALL_SIZE / 2 < padX + PADDLE_W / 2 - 4;	// chase the ball
			rightKey = p.x + BALL_SIZE / 2 > padX + PADDLE_W / 2 + 4;
		end
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
			abortRun("Timeout: the run went past its cycle limit");
	end

	initial begin
		startOfFrame = 1'b0;
		leftKey = 1'b0;
		rightKey = 1'b0;
		pause = 1'b0;
		levelRestart = 1'b0;
		level = '0;
		placeModel(INITIAL_Y_SPEED);
		hits = '0;
		@(posedge resetN);
		checkOutputs();
		driveInputs();
		repeat (RUN_CYCLES) begin
			@(posedge clk);
			stepModel();
			@(negedge clk);
			checkOutputs();
			driveInputs();
		end
		$display("Test completed successfully");
		$finish;
	end

endmodule

/* gameCore.f */
src/gamePkg.sv
src/ballController.sv
src/paddleController.sv
src/brickWall.sv
src/collisionDetector.sv
src/gameCore.sv
bench/clockGen.sv
bench/gameCoreTb.sv

/* src/ballController.sv */
`timescale 1ns/1ps

module ballController #(
	parameter int FRAC_BITS = 6
) (
	input	logic				clk,
	input	logic				resetN,
	input	logic				startOfFrame,
	input	logic				pause,
	input	logic				levelRestart,
	input	gamePkg::levelT		level,
	input	gamePkg::collisionT	collisions,
	input	gamePkg::fixedT		paddleSpeedX,
	output	gamePkg::pointT		ballPos
);
	import gamePkg::*;

	localparam fixedT START_X = fixedT'(INITIAL_X) <<< FRAC_BITS;
	localparam fixedT START_Y = fixedT'(INITIAL_Y) <<< FRAC_BITS;
	localparam fixedT START_SPEED_Y = fixedT'(INITIAL_Y_SPEED) <<< FRAC_BITS;

	fixedT posX;
	fixedT posY;
	fixedT speedX;
	fixedT speedY;
	fixedT restartSpeedY;

	logic movingUp;
	logic movingDown;
	logic movingLeft;
	logic movingRight;
	logic flipX;
	logic flipY;
	logic kickX;

	assign movingUp = speedY < 0;
	assign movingDown = speedY > 0;
	assign movingLeft = speedX < 0;
	assign movingRight = speedX > 0;

	// faster drop on higher levels
	assign restartSpeedY = fixedT'(INITIAL_Y_SPEED * (int'(level) + 1)) <<< FRAC_BITS;

	// ========================================================================
	// bounce rules
	// ========================================================================
	always_comb begin
		flipY = (collisions.borderTop && movingUp)
			|| (collisions.paddle && movingDown)
			|| (collisions.brick && collisions.brickEdge[2] && movingUp)
			|| (collisions.brick && collisions.brickEdge[0] && movingDown);

		flipX = (collisions.borderLeft && movingLeft)
			|| (collisions.borderRight && movingRight)
			|| (collisions.brick && collisions.brickEdge[3] && movingLeft)
			|| (collisions.brick && collisions.brickEdge[1] && movingRight);

		// paddle only kicks sideways when nothing reverses x
		kickX = !flipX && collisions.paddle && movingDown;
	end

	// ========================================================================
	// vertical
	// ========================================================================
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			speedY <= START_SPEED_Y;
			posY <= START_Y;
		end else if (levelRestart) begin
			speedY <= restartSpeedY;
			posY <= START_Y;
		end else if (!pause) begin
			if (flipY)
				speedY <= -speedY;
			if (startOfFrame)
				posY <= posY + speedY;	// old speed
		end
	end

	// ========================================================================
	// horizontal
	// ========================================================================
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			speedX <= '0;
			posX <= START_X;
		end else if (levelRestart) begin
			speedX <= '0;
			posX <= START_X;
		end else if (!pause) begin
			if (flipX)
				speedX <= -speedX;
			else if (kickX)
				speedX <= speedX + paddleSpeedX;
			if (startOfFrame)
				posX <= posX + speedX;
		end
	end

	assign ballPos.x = coordT'(posX >>> FRAC_BITS);
	assign ballPos.y = coordT'(posY >>> FRAC_BITS);

endmodule

/* src/brickWall.sv */
`timescale 1ns/1ps

module brickWall (
	input	logic				clk,
	input	logic				resetN,
	input	logic				pause,
	input	logic				levelRestart,
	input	gamePkg::pointT		ballPos,
	output	logic				brickHit,
	output	gamePkg::edgeCodeT	brickEdge,
	output	gamePkg::brickMaskT	brickAlive,
	output	gamePkg::hitCountT	hitCount
);
	import gamePkg::*;

	localparam int BRICK_PITCH = BRICK_W + BRICK_GAP;

	brickMaskT hitMask;	// one-hot mask of the touched brick

	function automatic int minOf(input int a, input int b);
		return (a < b) ? a : b;
	endfunction

	function automatic int maxOf(input int a, input int b);
		return (a > b) ? a : b;
	endfunction

	// ========================================================================
	// hit search where the lowest index wins
	// ========================================================================
	always_comb begin
		int ballL;
		int ballT;
		int brickL;
		int depthX;
		int depthY;

		ballL = int'(ballPos.x);
		ballT = int'(ballPos.y);
		brickHit = 1'b0;
		brickEdge = '0;
		hitMask = '0;
		depthX = 0;
		depthY = 0;

		for (int i = 0; i < NUM_BRICKS; i++) begin
			brickL = BRICK_X0 + i * BRICK_PITCH;
			if (!brickHit && brickAlive[i]
					&& ballL < brickL + BRICK_W && ballL + BALL_SIZE > brickL
					&& ballT < BRICK_Y + BRICK_H && ballT + BALL_SIZE > BRICK_Y) begin
				brickHit = 1'b1;
				hitMask[i] = 1'b1;
				depthX = minOf(ballL + BALL_SIZE, brickL + BRICK_W) - maxOf(ballL, brickL);
				depthY = minOf(ballT + BALL_SIZE, BRICK_Y + BRICK_H) - maxOf(ballT, BRICK_Y);

				// compare centres at double scale
				if (depthX <= depthY) begin
					if (2 * ballL + BALL_SIZE > 2 * brickL + BRICK_W)
						brickEdge = 4'b1000;	// ball's left face
					else
						brickEdge = 4'b0010;	// right face
				end else begin
					if (2 * ballT + BALL_SIZE > 2 * BRICK_Y + BRICK_H)
						brickEdge = 4'b0100;	// top face
					else
						brickEdge = 4'b0001;	// bottom face
				end
			end
		end
	end

	// ========================================================================
	// alive mask and counter
	// ========================================================================
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			brickAlive <= '1;
			hitCount <= '0;
		end else if (levelRestart) begin
			brickAlive <= '1;	// count carries over
		end else if (!pause && brickHit) begin
			brickAlive <= brickAlive & ~hitMask;
			hitCount <= hitCount + 1'b1;
		end
	end

endmodule

/* src/collisionDetector.sv */
`timescale 1ns/1ps

module collisionDetector (
	input	gamePkg::pointT		ballPos,
	input	gamePkg::coordT		paddleX,
	input	logic				brickHit,
	input	gamePkg::edgeCodeT	brickEdge,
	output	gamePkg::collisionT	collisions,
	output	logic				ballLost
);
	import gamePkg::*;

	int ballL;
	int ballT;
	int ballR;
	int ballB;
	int padL;
	int padR;

	logic overlapX;
	logic overlapY;

	// ========================================================================
	// ball box edges
	// ========================================================================
	assign ballL = int'(ballPos.x);
	assign ballT = int'(ballPos.y);
	assign ballR = ballL + BALL_SIZE;	// exclusive
	assign ballB = ballT + BALL_SIZE;

	assign padL = int'(paddleX);
	assign padR = padL + PADDLE_W;

	// ========================================================================
	// paddle box test
	// ========================================================================
	assign overlapX = (ballL < padR) && (ballR > padL);
	assign overlapY = (ballT < PADDLE_Y + PADDLE_H) && (ballB > PADDLE_Y);

	// ========================================================================
	// merged result
	// ========================================================================
	always_comb begin
		collisions.borderTop = ballT <= 0;
		collisions.borderLeft = ballL <= 0;
		collisions.borderRight = ballR >= SCREEN_W;
		collisions.paddle = overlapX && overlapY;
		collisions.brick = brickHit;
		// face code only means something with a hit
		collisions.brickEdge = brickHit ? brickEdge : '0;
	end

	assign ballLost = ballT >= SCREEN_H;	// past the bottom edge

endmodule

/* src/gameCore.sv */
`timescale 1ns/1ps

module gameCore #(
	parameter int FRAC_BITS = 6
) (
	input	logic				clk,
	input	logic				resetN,
	input	logic				startOfFrame,
	input	logic				leftKey,
	input	logic				rightKey,
	input	logic				pause,
	input	logic				levelRestart,
	input	gamePkg::levelT		level,
	output	gamePkg::pointT		ballPos,
	output	gamePkg::coordT		paddleX,
	output	gamePkg::collisionT	collisions,
	output	logic				ballLost,
	output	gamePkg::brickMaskT	brickAlive,
	output	gamePkg::hitCountT	hitCount
);
	import gamePkg::*;

	fixedT paddleSpeedX;
	logic brickHit;
	edgeCodeT brickEdge;

	// ========================================================================
	// motion
	// ========================================================================
	ballController #(
		.FRAC_BITS	(FRAC_BITS)
	) ballCtrl (
		.clk			(clk),
		.resetN			(resetN),
		.startOfFrame	(startOfFrame),
		.pause			(pause),
		.levelRestart	(levelRestart),
		.level			(level),
		.collisions		(collisions),
		.paddleSpeedX	(paddleSpeedX),
		.ballPos		(ballPos)
	);

	paddleController #(
		.FRAC_BITS	(FRAC_BITS)
	) paddleCtrl (
		.clk			(clk),
		.resetN			(resetN),
		.startOfFrame	(startOfFrame),
		.pause			(pause),
		.levelRestart	(levelRestart),
		.leftKey		(leftKey),
		.rightKey		(rightKey),
		.paddleX		(paddleX),
		.paddleSpeedX	(paddleSpeedX)
	);

	// ========================================================================
	// collisions
	// ========================================================================
	brickWall wall (
		.clk			(clk),
		.resetN			(resetN),
		.pause			(pause),
		.levelRestart	(levelRestart),
		.ballPos		(ballPos),
		.brickHit		(brickHit),
		.brickEdge		(brickEdge),
		.brickAlive		(brickAlive),
		.hitCount		(hitCount)
	);

	collisionDetector detector (
		.ballPos	(ballPos),
		.paddleX	(paddleX),
		.brickHit	(brickHit),
		.brickEdge	(brickEdge),
		.collisions	(collisions),
		.ballLost	(ballLost)
	);

endmodule

/* src/gamePkg.sv */
package gamePkg;

	// ========================================================================
	// widths
	// ========================================================================
	localparam int NUM_BRICKS = 4;

	typedef logic signed [10:0] coordT;	// screen pixel
	typedef logic signed [31:0] fixedT;	// position or speed with FRAC_BITS fraction bits
	typedef logic [3:0] levelT;
	typedef logic [NUM_BRICKS-1:0] brickMaskT;
	typedef logic [7:0] hitCountT;
	typedef logic [3:0] edgeCodeT;	// bits 3..0 are the ball's left, top, right and bottom faces

	typedef struct packed {
		coordT x;
		coordT y;
	} pointT;

	typedef struct packed {
		logic borderTop;
		logic borderLeft;
		logic borderRight;
		logic paddle;
		logic brick;
		edgeCodeT brickEdge;
	} collisionT;

	// ========================================================================
	// geometry
	// ========================================================================
	localparam int SCREEN_W = 640;
	localparam int SCREEN_H = 480;
	localparam int BALL_SIZE = 16;
	localparam int PADDLE_W = 64;
	localparam int PADDLE_H = 8;
	localparam int PADDLE_Y = 440;
	localparam int PADDLE_START_X = 288;
	localparam int INITIAL_X = 312;
	localparam int INITIAL_Y = 200;
	localparam int BRICK_W = 120;
	localparam int BRICK_H = 20;
	localparam int BRICK_Y = 60;
	localparam int BRICK_X0 = 40;
	localparam int BRICK_GAP = 40;

	// speeds in whole pixels per frame
	localparam int INITIAL_Y_SPEED = 2;
	localparam int PADDLE_STEP = 4;

endpackage

/* src/paddleController.sv */
`timescale 1ns/1ps

module paddleController #(
	parameter int FRAC_BITS = 6
) (
	input	logic			clk,
	input	logic			resetN,
	input	logic			startOfFrame,
	input	logic			pause,
	input	logic			levelRestart,
	input	logic			leftKey,
	input	logic			rightKey,
	output	gamePkg::coordT	paddleX,
	output	gamePkg::fixedT	paddleSpeedX
);
	import gamePkg::*;

	localparam int MAX_X = SCREEN_W - PADDLE_W;
	localparam fixedT STEP_SPEED = fixedT'(PADDLE_STEP) <<< FRAC_BITS;

	logic moveLeft;
	logic moveRight;
	logic clamped;
	int target;
	coordT nextX;
	fixedT nextSpeed;

	assign moveLeft = leftKey && !rightKey;
	assign moveRight = rightKey && !leftKey;

	always_comb begin
		target = int'(paddleX);
		if (moveRight)
			target = int'(paddleX) + PADDLE_STEP;
		else if (moveLeft)
			target = int'(paddleX) - PADDLE_STEP;

		clamped = 1'b0;
		if (target < 0) begin
			target = 0;
			clamped = 1'b1;
		end else if (target > MAX_X) begin
			target = MAX_X;
			clamped = 1'b1;
		end
		nextX = coordT'(target);

		if (clamped || !(moveLeft || moveRight))
			nextSpeed = '0;	// stopped at a wall or idle
		else if (moveRight)
			nextSpeed = STEP_SPEED;
		else
			nextSpeed = -STEP_SPEED;
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			paddleX <= coordT'(PADDLE_START_X);
			paddleSpeedX <= '0;
		end else if (levelRestart) begin
			paddleX <= coordT'(PADDLE_START_X);
			paddleSpeedX <= '0;
		end else if (!pause && startOfFrame) begin
			paddleX <= nextX;
			paddleSpeedX <= nextSpeed;
		end
	end

endmodule
